/* adc_cfg.svh */
/* build-time constants for the adc scan; ADC_NCH up to 8 (mask sits in CTRL 15:8)
   ADC_SETTLE must be 1 or more, register offsets are byte addresses on an 8-bit paddr */
`ifndef ADC_CFG_SVH
`define ADC_CFG_SVH

// --------------------
// converter
// --------------------
`define ADC_NCH     8      // scanned channels
`define ADC_BITS    10     // sar resolution
`define ADC_LSB_MV  2      // dac step in mV
`define ADC_SETTLE  4      // hold-to-conversion cycles

// --------------------
// apb register map
// --------------------
`define ADC_REG_CTRL  8'h00  // start, mask
`define ADC_REG_STAT  8'h04  // busy, done
`define ADC_REG_RES0  8'h10  // result of ch n at +4n

`endif

/* adc_pkg.sv */
/* shared types for the adc scan
   divider table mirrors the front-end taps, one entry per channel */
`include "adc_cfg.svh"

package adc_pkg;

   // scan sequencer states, one pass per enabled channel
   typedef enum logic [2:0] {
      IDLE,    // waiting for start
      PICK,    // choose channel, reset s/h
      SAMPLE,  // track input
      SETTLE,  // hold, let dac settle
      CONV,    // sar search
      STORE    // write result
   } scan_state_t;

   typedef logic [$clog2(`ADC_NCH)-1:0] chan_t;  // channel index
   typedef logic [`ADC_BITS-1:0]        code_t;  // dac code / result
   typedef logic [15:0]                 mv_t;    // voltage in mV

   // fixed input dividers
   // ch0 vin/20, ch1 vo/10, ch3 dp/3 style taps, rest direct or /2 /4
   localparam int unsigned CH_DIV [`ADC_NCH] = '{
      20,  // ch0
      10,  // ch1
      1,   // ch2
      3,   // ch3
      2,   // ch4
      4,   // ch5
      1,   // ch6
      1    // ch7
   };

endpackage

/* adc_if.sv */
/* core logic to analog front end, one comparator shared by all channels
   ctl side drives select, s/h and dac; ana side returns comp_o */
`timescale 1ns/10ps
`include "adc_cfg.svh"

interface adc_if import adc_pkg::*; ();

   chan_t chan;      // mux select
   logic  sh_rst;    // clear sample cap
   logic  sh_hold;   // freeze sample
   code_t dac_code;  // reference dac
   logic  comp_o;    // sample > dac level

   // core side
   modport ctl (
      output chan,
      output sh_rst,
      output sh_hold,
      output dac_code,
      input  comp_o
   );

   // analog model side
   modport ana (
      input  chan,
      input  sh_rst,
      input  sh_hold,
      input  dac_code,
      output comp_o
   );

endinterface

/* settle_timer.sv */
/* settle delay after hold, one expired pulse per load
   ADC_SETTLE of at least 1, a new load restarts the count */
`timescale 1ns/10ps
`include "adc_cfg.svh"

module settle_timer (
   input  logic OSC_O,
   input  logic r_rstz,
   input  logic load,
   output logic expired
);

   localparam int CW = $clog2(`ADC_SETTLE + 1);

   logic [CW-1:0] cnt;  // 0 means idle

   // load in SAMPLE, so SETTLE sees ADC_SETTLE in its first cycle
   always_ff @(posedge OSC_O) begin
      if (r_rstz) begin
         cnt <= '0;
      end else if (load) begin
         cnt <= CW'(`ADC_SETTLE);
      end else if (cnt != '0) begin
         cnt <= cnt - 1'b1;  // down to zero, then parked
      end
   end

   // high in the cycle that takes the count to zero
   // exactly ADC_SETTLE cycles after the load edge
   assign expired = (cnt == CW'(1)) & ~load;

endmodule

/* sar_approx.sv */
/* successive approximation, one bit per cycle from msb down
   result holds the last code until the next start; done in the last trial cycle */
`timescale 1ns/10ps
`include "adc_cfg.svh"

module sar_approx import adc_pkg::*; (
   input  logic  OSC_O,
   input  logic  r_rstz,
   input  logic  start,
   output logic  done,
   output code_t result,
   adc_if.ctl    ana   // dac_code out, comp_o in
);

   code_t               code_q;  // bits decided so far
   logic [`ADC_BITS-1:0] bit_q;   // one-hot trial bit, 0 when idle

   // --------------------
   // search
   // --------------------
   always_ff @(posedge OSC_O) begin
      if (r_rstz) begin
         code_q <= '0;
         bit_q  <= '0;
      end else if (start) begin
         code_q <= '0;
         bit_q  <= {1'b1, {(`ADC_BITS-1){1'b0}}};  // msb first
      end else if (bit_q != '0) begin
         // sample still above trial level, keep the bit
         if (ana.comp_o) begin
            code_q <= code_q | bit_q;
         end
         bit_q <= bit_q >> 1;
      end
   end

   // trial level seen by the comparator
   assign ana.dac_code = code_q | bit_q;

   // lsb trial in flight, last decision lands on this edge
   assign done = bit_q[0];

   // largest code with code*lsb below the sample
   // saturates at all ones, zero for an empty sample
   assign result = code_q;

endmodule

/* scan_fsm.sv */
/* scan sequencer, channels visited in ascending order of the mask captured at start
   start is ignored while busy; empty mask gives done without a scan */
`timescale 1ns/10ps
`include "adc_cfg.svh"

module scan_fsm import adc_pkg::*; (
   input  logic               OSC_O,
   input  logic               r_rstz,
   input  logic [`ADC_NCH-1:0] mask,
   input  logic               start,
   output logic               tmr_load,
   input  logic               tmr_expired,
   output logic               sar_start,
   input  logic               sar_done,
   output logic               res_we,
   output chan_t              res_chan,
   output logic               busy,
   output logic               done_pulse,
   adc_if.ctl                 ana
);

   scan_state_t         state, state_nx;
   logic [`ADC_NCH-1:0] pend;    // channels still to convert
   chan_t               chan_q;  // channel in progress
   chan_t               nxt;     // lowest pending channel

   // --------------------
   // next channel search
   // --------------------
   // finished bits are cleared, so the lowest pending one is at or above chan_q
   always_comb begin
      nxt = '0;
      for (int i = `ADC_NCH - 1; i >= 0; i--) begin
         if (pend[i]) nxt = chan_t'(i);
      end
   end

   always_ff @(posedge OSC_O) begin
      if (r_rstz) begin
         state  <= IDLE;
         pend   <= '0;
         chan_q <= '0;
      end else begin
         state <= state_nx;
         if (state == IDLE && start) pend <= mask;  // snapshot
         if (state == PICK) begin
            chan_q     <= nxt;
            pend[nxt]  <= 1'b0;  // claimed
         end
      end
   end

   always_comb begin
      state_nx = state;
      case (state)
         IDLE:    if (start && mask != '0) state_nx = PICK;
         PICK:    state_nx = SAMPLE;
         SAMPLE:  state_nx = SETTLE;
         SETTLE:  if (tmr_expired) state_nx = CONV;
         CONV:    if (sar_done) state_nx = STORE;
         STORE:   state_nx = (pend == '0) ? IDLE : PICK;
         default: state_nx = IDLE;
      endcase
   end

   // --------------------
   // outputs
   // --------------------
   assign busy       = (state != IDLE);
   assign done_pulse = (state == IDLE && start && mask == '0)  // empty scan
                     | (state == STORE && pend == '0);       // last channel
   assign tmr_load   = (state == SAMPLE);                    // settle starts next
   assign sar_start  = (state == SETTLE) & tmr_expired;
   assign res_we     = (state == STORE);
   assign res_chan   = chan_q;

   assign ana.chan    = chan_q;
   assign ana.sh_rst  = (state == PICK);
   assign ana.sh_hold = (state == SETTLE) | (state == CONV) | (state == STORE);

endmodule

/* ana_cmp_model.sv */
/* behavioral front end for simulation only, not for synthesis
   divider rounds down, sample updates on OSC_O, comparator is ideal */
`timescale 1ns/10ps
`include "adc_cfg.svh"

module ana_cmp_model import adc_pkg::*; (
   input mv_t [`ADC_NCH-1:0] ch_mv,  // pad voltages in mV
   adc_if.ana                ana,
   input logic               OSC_O
);

   mv_t         tap;         // divided, selected input
   mv_t         samp = '0;   // hold cap voltage
   int unsigned trial_mv;    // dac level

   // --------------------
   // mux and divider
   // --------------------
   assign tap = mv_t'(ch_mv[ana.chan] / CH_DIV[ana.chan]);

   // --------------------
   // sample and hold
   // --------------------
   always @(posedge OSC_O) begin
      if (ana.sh_rst) begin
         samp <= '0;       // discharge
      end else if (!ana.sh_hold) begin
         samp <= tap;      // track
      end
   end

   // --------------------
   // dac and comparator
   // --------------------
   assign trial_mv   = ana.dac_code * `ADC_LSB_MV;
   assign ana.comp_o = (samp > trial_mv);  // settles same cycle

endmodule

/* scan_regs.sv */
/* apb slave, zero wait states, writes land on the access cycle
   mask is forwarded during the CTRL write so a start sees its own mask */
`timescale 1ns/10ps
`include "adc_cfg.svh"

module scan_regs import adc_pkg::*; (
   input  logic                OSC_O,
   input  logic                r_rstz,
   input  logic [7:0]          paddr,
   input  logic                psel,
   input  logic                penable,
   input  logic                pwrite,
   input  logic [31:0]         pwdata,
   output logic [31:0]         prdata,
   output logic                pready,
   output logic [`ADC_NCH-1:0] mask,
   output logic                start,
   input  logic                busy,
   input  logic                done_pulse,
   input  logic                res_we,
   input  chan_t               res_chan,
   input  code_t               res_code
);

   logic                      wr_acc;   // write access phase
   logic                      ctrl_wr, stat_wr;
   logic [`ADC_NCH-1:0]       mask_q;
   logic                      done_q;   // sticky
   code_t [`ADC_NCH-1:0]      res_q;
   logic [7:0]                rel;      // offset into result block
   logic                      res_hit;
   chan_t                     res_idx;

   assign wr_acc  = psel & penable & pwrite;
   assign ctrl_wr = wr_acc & (paddr == `ADC_REG_CTRL);
   assign stat_wr = wr_acc & (paddr == `ADC_REG_STAT);

   // --------------------
   // control / status
   // --------------------
   always_ff @(posedge OSC_O) begin
      if (r_rstz) begin
         mask_q <= '0;
         done_q <= 1'b0;
      end else begin
         if (ctrl_wr) mask_q <= pwdata[8 +: `ADC_NCH];
         if (done_pulse) begin
            done_q <= 1'b1;  // set wins over clear
         end else if (stat_wr && pwdata[1]) begin
            done_q <= 1'b0;  // write 1 to clear
         end
      end
   end

   assign mask  = ctrl_wr ? pwdata[8 +: `ADC_NCH] : mask_q;
   assign start = ctrl_wr & pwdata[0];  // pulse only, reads back 0

   // results, written by the sequencer in STORE
   always_ff @(posedge OSC_O) begin
      if (r_rstz) begin
         res_q <= '0;
      end else if (res_we) begin
         res_q[res_chan] <= res_code;
      end
   end

   // --------------------
   // read mux
   // --------------------
   assign rel     = paddr - `ADC_REG_RES0;  // wraps high below RES0
   assign res_hit = (rel < 8'(4 * `ADC_NCH)) && (rel[1:0] == 2'b00);
   assign res_idx = chan_t'(rel >> 2);

   always_comb begin
      prdata = '0;
      if (res_hit) prdata = 32'(res_q[res_idx]);
      else if (paddr == `ADC_REG_CTRL) prdata = 32'({mask_q, 8'h00});
      else if (paddr == `ADC_REG_STAT) prdata = {30'd0, done_q, busy};
   end

   assign pready = 1'b1;  // no wait states

endmodule

/* adc_top.sv */
/* adc scan top, apb slave plus scan core plus analog model
   eight channel voltage ports in mV, clock and reset from outside */
`timescale 1ns/10ps
`include "adc_cfg.svh"

module adc_top import adc_pkg::*; (
   input  logic        OSC_O,
   input  logic        r_rstz,
   input  logic [7:0]  paddr,
   input  logic        psel,
   input  logic        penable,
   input  logic        pwrite,
   input  logic [31:0] pwdata,
   output logic [31:0] prdata,
   output logic        pready,
   input  mv_t         ch0_mv, ch1_mv, ch2_mv, ch3_mv,
   input  mv_t         ch4_mv, ch5_mv, ch6_mv, ch7_mv
);

   logic [`ADC_NCH-1:0] mask;
   logic                start, busy, done_pulse;
   logic                tmr_load, tmr_expired;
   logic                sar_start, sar_done;
   logic                res_we;
   chan_t               res_chan;
   code_t               res_code;
   mv_t [`ADC_NCH-1:0]  ch_mv;

   assign ch_mv = {ch7_mv, ch6_mv, ch5_mv, ch4_mv, ch3_mv, ch2_mv, ch1_mv, ch0_mv};

   adc_if u_if ();  // core to front end

   scan_regs u_regs (
      .OSC_O, .r_rstz, .paddr, .psel, .penable, .pwrite, .pwdata, .prdata, .pready,
      .mask, .start, .busy, .done_pulse, .res_we, .res_chan, .res_code
   );

   scan_fsm u_fsm (
      .OSC_O, .r_rstz, .mask, .start, .tmr_load, .tmr_expired, .sar_start, .sar_done,
      .res_we, .res_chan, .busy, .done_pulse, .ana(u_if.ctl)
   );

   settle_timer u_tmr (.OSC_O, .r_rstz, .load(tmr_load), .expired(tmr_expired));

   sar_approx u_sar (
      .OSC_O, .r_rstz, .start(sar_start), .done(sar_done), .result(res_code),
      .ana(u_if.ctl)
   );

   ana_cmp_model u_ana (.ch_mv, .ana(u_if.ana), .OSC_O);

endmodule

/* adc_chk.sv */
/* protocol assertions bound into adc_top
   apb handshake order, s/h control exclusion, scan end with done */
`timescale 1ns/10ps

module adc_chk (
   input logic OSC_O,
   input logic r_rstz,
   input logic psel,
   input logic penable,
   input logic sh_rst,
   input logic sh_hold,
   input logic busy,
   input logic done_pulse
);

   int unsigned n_fail = 0;  // assertion failures so far

   // --------------------
   // apb
   // --------------------
   a_pen_psel: assert property (@(posedge OSC_O) disable iff (r_rstz)
      penable |-> psel)
      else begin
         $error("penable high without psel");
         n_fail++;
      end

   a_pen_follow: assert property (@(posedge OSC_O) disable iff (r_rstz)
      (psel && !penable) |=> (psel && penable))  // setup then access
      else begin
         $error("access phase did not follow setup");
         n_fail++;
      end

   a_pen_one: assert property (@(posedge OSC_O) disable iff (r_rstz)
      penable |=> !penable)  // one access cycle
      else begin
         $error("penable held longer than one cycle");
         n_fail++;
      end

   // --------------------
   // front end and scan
   // --------------------
   a_sh_excl: assert property (@(posedge OSC_O) disable iff (r_rstz)
      !(sh_hold && sh_rst))
      else begin
         $error("sh_hold and sh_rst high together");
         n_fail++;
      end

   a_busy_done: assert property (@(posedge OSC_O) disable iff (r_rstz)
      $fell(busy) |-> $past(done_pulse))
      else begin
         $error("busy fell without done");
         n_fail++;
      end

endmodule

bind adc_top adc_chk chk (
   .OSC_O, .r_rstz, .psel, .penable,
   .sh_rst(u_if.sh_rst), .sh_hold(u_if.sh_hold),
   .busy, .done_pulse
);

/* adc_tb.sv */
/* table-driven testbench for adc_top, apb reads poll STAT for done
   expected codes from the divider table and sar rule, watchdog bounds the run */
`timescale 1ns/10ps
`include "adc_cfg.svh"

module adc_tb import adc_pkg::*; ();

   localparam int NROWS  = 7;
   localparam int PERIOD = 40;
   localparam int WD_CYC = (NROWS + 2) * `ADC_NCH * 40 + 2000;  // rows x ch x 40, plus margin
   localparam int unsigned DIV [`ADC_NCH] = '{20, 10, 1, 3, 2, 4, 1, 1};  // input taps

   logic        OSC_O;
   logic        r_rstz;
   logic [7:0]  paddr;
   logic        psel, penable, pwrite;
   logic [31:0] pwdata, prdata;
   logic        pready;
   mv_t         ch_v [`ADC_NCH];  // pad voltages

   logic [`ADC_NCH-1:0] tbl_mask [NROWS];
   int unsigned         tbl_mv [NROWS][`ADC_NCH];
   code_t               exp_res [`ADC_NCH];   // model of result regs
   integer              seed = 32'h99e1;
   logic [31:0]         rd;

   adc_top dut (
      .OSC_O, .r_rstz, .paddr, .psel, .penable, .pwrite, .pwdata, .prdata, .pready,
      .ch0_mv(ch_v[0]), .ch1_mv(ch_v[1]), .ch2_mv(ch_v[2]), .ch3_mv(ch_v[3]),
      .ch4_mv(ch_v[4]), .ch5_mv(ch_v[5]), .ch6_mv(ch_v[6]), .ch7_mv(ch_v[7])
   );

   initial begin
      OSC_O = 1'b0;
      forever #(PERIOD / 2) OSC_O = ~OSC_O;
   end

   initial begin
      #(WD_CYC * PERIOD);
      fail_stop("watchdog expired, a scan never reported done");
   end

   // --------------------
   // reporting
   // --------------------
   task automatic fail_stop(input string why);
      $display("%s", why);
      $display("STATUS: FAIL");
      $fatal(1, "run stopped at first error");
   endtask

   task automatic check_code(input string name, input code_t exp, input code_t act);
      if (act !== exp) fail_stop($sformatf("ERR %s exp %0d got %0d", name, exp, act));
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (act !== exp) fail_stop($sformatf("ERR %s exp %b got %b", name, exp, act));
   endtask

   // --------------------
   // apb
   // --------------------
   task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
      @(posedge OSC_O);
      #2;
      paddr   = addr;
      pwdata  = data;
      pwrite  = 1'b1;
      psel    = 1'b1;   // setup
      penable = 1'b0;
      @(posedge OSC_O);
      #2 penable = 1'b1;  // access, lands next edge
      @(posedge OSC_O);
      #2;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
      @(posedge OSC_O);
      #2;
      paddr   = addr;
      pwrite  = 1'b0;
      psel    = 1'b1;
      penable = 1'b0;
      @(posedge OSC_O);
      #2 penable = 1'b1;
      @(negedge OSC_O);   // mid access phase
      data = prdata;
      check_bit("pready", 1'b1, pready);
      @(posedge OSC_O);
      #2;
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   // sample = mv / div rounded down, code = largest c with c*lsb below sample
   function automatic code_t expect_code(input int unsigned mv, input int unsigned div);
      int unsigned samp;
      int unsigned c;
      samp = mv / div;
      if (samp == 0) return '0;
      c = (samp - 1) / `ADC_LSB_MV;
      if (c > (1 << `ADC_BITS) - 1) c = (1 << `ADC_BITS) - 1;  // full scale clamp
      return code_t'(c);
   endfunction

   task automatic check_results(input string label);
      for (int c = 0; c < `ADC_NCH; c++) begin
         apb_read(8'(`ADC_REG_RES0 + 4 * c), rd);
         check_code($sformatf("%s ch%0d", label, c), exp_res[c], code_t'(rd));
      end
   endtask

   task automatic wait_done(input string label);
      do apb_read(`ADC_REG_STAT, rd);  // watchdog covers a stuck scan
      while (!rd[1]);
      check_bit({label, " busy at done"}, 1'b0, rd[0]);
   endtask

   // --------------------
   // stimulus table
   // --------------------
   task automatic build_table();
      int r32;
      tbl_mask[0] = 8'hFF;  // mid range
      tbl_mv[0]   = '{12000, 6000, 900, 2700, 1500, 3300, 1234, 777};
      tbl_mask[1] = 8'hFF;  // edges, zero and beyond full scale
      tbl_mv[1]   = '{0, 65535, 2047, 65535, 4095, 9000, 2046, 0};
      tbl_mask[2] = 8'hA4;  // sparse, ch2 ch5 ch7
      tbl_mv[2]   = '{5000, 5000, 300, 5000, 5000, 1000, 5000, 1500};
      tbl_mask[3] = 8'h00;  // empty scan
      tbl_mv[3]   = '{4444, 4444, 4444, 4444, 4444, 4444, 4444, 4444};
      for (int r = 4; r < NROWS; r++) begin
         r32 = $random(seed);
         tbl_mask[r] = (r == 4) ? 8'hFF : r32[`ADC_NCH-1:0];
         for (int c = 0; c < `ADC_NCH; c++) begin
            // mostly inside full scale after the divider
            tbl_mv[r][c] = ($unsigned($random(seed)) % 2048) * DIV[c]
                         + $unsigned($random(seed)) % 32;
         end
      end
   endtask

   task automatic run_row(input int r);
      @(posedge OSC_O);
      #2;
      for (int c = 0; c < `ADC_NCH; c++) ch_v[c] = mv_t'(tbl_mv[r][c]);
      apb_write(`ADC_REG_STAT, 32'h2);  // clear done
      apb_write(`ADC_REG_CTRL, {16'h0, tbl_mask[r], 8'h01});
      for (int c = 0; c < `ADC_NCH; c++) begin
         if (tbl_mask[r][c]) exp_res[c] = expect_code(tbl_mv[r][c], DIV[c]);
      end
      apb_read(`ADC_REG_STAT, rd);
      if (tbl_mask[r] == '0) begin
         check_bit($sformatf("row%0d empty mask done", r), 1'b1, rd[1]);
         check_bit($sformatf("row%0d empty mask busy", r), 1'b0, rd[0]);
      end else begin
         check_bit($sformatf("row%0d busy after start", r), 1'b1, rd[0]);
         wait_done($sformatf("row%0d", r));
      end
      check_results($sformatf("row%0d", r));
   endtask

   // done sticky, write-1 clear, start during a scan dropped
   task automatic sticky_and_busy();
      @(posedge OSC_O);
      #2;
      for (int c = 0; c < `ADC_NCH; c++) begin
         // odd sample on a new code, stale results stand out
         ch_v[c] = mv_t'(((exp_res[c] ^ 10'h200) * 2 + 1) * DIV[c]);
      end
      apb_write(`ADC_REG_STAT, 32'h2);
      apb_write(`ADC_REG_CTRL, {16'h0, 8'hFF, 8'h01});
      for (int c = 0; c < `ADC_NCH; c++) exp_res[c] = expect_code(int'(ch_v[c]), DIV[c]);
      apb_read(`ADC_REG_STAT, rd);
      check_bit("busy in scan", 1'b1, rd[0]);
      apb_write(`ADC_REG_CTRL, {16'h0, 8'h01, 8'h01});  // should be ignored
      wait_done("sticky scan");
      repeat (4) @(posedge OSC_O);
      apb_read(`ADC_REG_STAT, rd);
      check_bit("start while busy ignored", 1'b0, rd[0]);
      check_bit("done sticky", 1'b1, rd[1]);
      apb_write(`ADC_REG_STAT, 32'h0);
      apb_read(`ADC_REG_STAT, rd);
      check_bit("done kept on write 0", 1'b1, rd[1]);
      apb_write(`ADC_REG_STAT, 32'h2);
      apb_read(`ADC_REG_STAT, rd);
      check_bit("done cleared by write 1", 1'b0, rd[1]);
      check_results("sticky");
   endtask

   // --------------------
   // main sequence
   // --------------------
   initial begin
      r_rstz  = 1'b1;
      paddr   = '0;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
      pwdata  = '0;
      for (int c = 0; c < `ADC_NCH; c++) begin
         ch_v[c]    = '0;
         exp_res[c] = '0;
      end
      build_table();
      repeat (5) @(posedge OSC_O);
      #2 r_rstz = 1'b0;

      apb_read(`ADC_REG_STAT, rd);  // reset state
      check_bit("reset busy", 1'b0, rd[0]);
      check_bit("reset done", 1'b0, rd[1]);
      check_results("reset");

      for (int r = 0; r < NROWS; r++) run_row(r);
      sticky_and_busy();

      if (dut.chk.n_fail != 0) begin
         fail_stop("a protocol assertion in the bound checker failed");
      end else begin
         $display("STATUS: PASS");
         $finish;
      end
   end

endmodule

/* sources.f */
+incdir+.
adc_pkg.sv
adc_if.sv
settle_timer.sv
sar_approx.sv
scan_fsm.sv
ana_cmp_model.sv
scan_regs.sv
adc_top.sv
adc_chk.sv
adc_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := adc_tb
FLIST     := sources.f
VFLAGS    := --binary --timing --assert -Wno-fatal --top-module $(TOP)
LOG       := sim.log

SRCS := $(wildcard *.sv *.svh)
BIN  := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST)

run: $(BIN)
	-$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
